// ==== common/sample_pkg.sv ====
package sample_pkg;

    //////////////////////////////
    // Sample word geometry
    //////////////////////////////

    // Sensor channel tag
    localparam int CHANNEL_WIDTH = 4;

    // Raw sensor reading
    localparam int VALUE_WIDTH = 16;

    //////////////////////////////
    // Sample formats
    //////////////////////////////

    // Word kept in the history RAM, 20 bits
    typedef struct packed {
        logic [CHANNEL_WIDTH-1:0] channel;
        logic [VALUE_WIDTH-1:0]   value;
    } sample_t;

    // Incoming stream beat, 22 bits
    // Trigger only matters while the buffer is armed
    typedef struct packed {
        logic    valid;
        logic    trigger;
        sample_t sample;
    } sample_beat_t;

endpackage

// ==== common/capture_pkg.sv ====
package capture_pkg;

    //////////////////////////////
    // Buffer geometry
    //////////////////////////////

    localparam int BUFFER_DEPTH = 256;
    localparam int ADDRESS_WIDTH = $clog2(BUFFER_DEPTH);

    // Window split around the trigger sample
    localparam int PRETRIGGER_COUNT = 64;
    localparam int POSTTRIGGER_COUNT = BUFFER_DEPTH - PRETRIGGER_COUNT - 1;

    // RAM output register on, so one extra cycle on top of the registered read
    localparam int READ_PIPELINED = 1;
    localparam int READ_LATENCY = 1 + READ_PIPELINED;

    //////////////////////////////
    // Capture FSM states
    //////////////////////////////

    typedef enum logic [1:0] {
        FILLING,
        ARMED,
        TRIGGERED,
        FROZEN
    } capture_state_t;

    //////////////////////////////
    // Readout formats
    //////////////////////////////

    // Index is relative to the window start
    typedef struct packed {
        logic                     valid;
        logic [ADDRESS_WIDTH-1:0] index;
    } read_request_t;

    typedef struct packed {
        logic                     valid;
        logic [ADDRESS_WIDTH-1:0] index;
        sample_pkg::sample_t      sample;
    } read_response_t;

endpackage

// ==== hdl/generic_block_ram.sv ====
module generic_block_ram #(
    parameter int DATA_WIDTH       = 16,
    parameter int DATA_DEPTH       = 4096,
    parameter int PIPELINED_OUTPUT = 1
) (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          write_enable,
    input  logic [DATA_WIDTH-1:0]         write_data,
    input  logic [$clog2(DATA_DEPTH)-1:0] write_address,
    input  logic [$clog2(DATA_DEPTH)-1:0] read_address,
    output logic [DATA_WIDTH-1:0]         read_data
);

    logic [DATA_WIDTH-1:0] memory [DATA_DEPTH];
    logic [DATA_WIDTH-1:0] memory_read_data;
    logic [DATA_WIDTH-1:0] pipelined_read_data;

    //////////////////////////////
    // Storage array
    //////////////////////////////

    // Whole array clears on reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int entry = 0; entry < DATA_DEPTH; entry++) begin
                memory[entry] <= '0;
            end
        end else if (write_enable) begin
            memory[write_address] <= write_data;
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    // Registered read, old data on a same-address write
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            memory_read_data <= '0;
        end else begin
            memory_read_data <= memory[read_address];
        end
    end

    // Second stage for timing on wide or deep arrays
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pipelined_read_data <= '0;
        end else begin
            pipelined_read_data <= memory_read_data;
        end
    end

    // Output tap picked by the pipelining option
    assign read_data = (PIPELINED_OUTPUT != 0) ? pipelined_read_data : memory_read_data;

endmodule

// ==== capture/capture_write_control.sv ====
module capture_write_control (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  sample_pkg::sample_beat_t              sample_in,
    input  logic                                  rearm,
    output capture_pkg::capture_state_t           capture_state,
    output logic                                  write_enable,
    output logic [capture_pkg::ADDRESS_WIDTH-1:0] write_address,
    output sample_pkg::sample_t                   write_data,
    output logic                                  frozen,
    output logic [capture_pkg::ADDRESS_WIDTH-1:0] window_start
);

    import capture_pkg::*;

    capture_state_t           state;
    capture_state_t           next_state;
    logic [ADDRESS_WIDTH-1:0] write_pointer;
    logic [ADDRESS_WIDTH-1:0] fill_count;
    logic [ADDRESS_WIDTH-1:0] post_count;
    logic                     fill_done;
    logic                     trigger_seen;
    logic                     post_done;

    //////////////////////////////
    // Write port
    //////////////////////////////

    // Input stream goes straight to the RAM unless the window is held
    assign write_enable  = sample_in.valid && (state != FROZEN);
    assign write_address = write_pointer;
    assign write_data    = sample_in.sample;

    assign frozen        = (state == FROZEN);
    assign capture_state = state;

    // Events qualified by an actual write
    assign fill_done    = write_enable && (fill_count == ADDRESS_WIDTH'(PRETRIGGER_COUNT - 1));
    assign trigger_seen = write_enable && sample_in.trigger;
    assign post_done    = write_enable && (post_count == ADDRESS_WIDTH'(POSTTRIGGER_COUNT - 1));

    //////////////////////////////
    // Capture FSM
    //////////////////////////////

    always_comb begin
        next_state = state;
        unique case (state)
            FILLING: begin
                // Trigger flags ignored until the pre-trigger part is full
                if (fill_done) begin
                    next_state = ARMED;
                end
            end
            ARMED: begin
                if (trigger_seen) begin
                    next_state = TRIGGERED;
                end
            end
            TRIGGERED: begin
                if (post_done) begin
                    next_state = FROZEN;
                end
            end
            FROZEN: begin
                if (rearm) begin
                    next_state = FILLING;
                end
            end
            default: next_state = FILLING;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= FILLING;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // Pointer and counters
    //////////////////////////////

    // Pointer wraps freely across captures
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            fill_count    <= '0;
            post_count    <= '0;
            window_start  <= '0;
        end else begin
            if (write_enable) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (state == FILLING && write_enable) begin
                fill_count <= fill_count + 1'b1;
            end else if (state == FROZEN && rearm) begin
                fill_count <= '0;
            end
            if (state == ARMED && trigger_seen) begin
                post_count   <= '0;
                // Index 0 sits PRETRIGGER_COUNT entries behind the trigger, modulo depth
                window_start <= write_pointer - ADDRESS_WIDTH'(PRETRIGGER_COUNT);
            end else if (state == TRIGGERED && write_enable) begin
                post_count <= post_count + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A full window ends where it starts, so any write while held moves the pointer off
    frozen_blocks_writes: assert property (
        @(posedge clock) disable iff (!reset_n) frozen |-> write_pointer == window_start
    );

    // Leaving FROZEN always lands in FILLING with a fresh fill count
    frozen_exits_to_filling: assert property (
        @(posedge clock) disable iff (!reset_n)
        state == FROZEN |=> state == FROZEN || (state == FILLING && fill_count == '0)
    );

endmodule

// ==== capture/capture_readout.sv ====
module capture_readout (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  capture_pkg::read_request_t            read_request,
    input  logic                                  frozen,
    input  logic [capture_pkg::ADDRESS_WIDTH-1:0] window_start,
    input  sample_pkg::sample_t                   read_data,
    output logic [capture_pkg::ADDRESS_WIDTH-1:0] read_address,
    output capture_pkg::read_response_t           read_response
);

    import capture_pkg::*;

    logic                     request_accepted;
    logic                     valid_pipe [READ_LATENCY];
    logic [ADDRESS_WIDTH-1:0] index_pipe [READ_LATENCY];

    //////////////////////////////
    // Address mapping
    //////////////////////////////

    // Window index to RAM address, wraps at the buffer depth
    assign read_address     = window_start + read_request.index;
    assign request_accepted = read_request.valid && frozen;

    //////////////////////////////
    // Latency alignment
    //////////////////////////////

    // Dropped requests enter as bubbles
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int stage = 0; stage < READ_LATENCY; stage++) begin
                valid_pipe[stage] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= request_accepted;
            for (int stage = 1; stage < READ_LATENCY; stage++) begin
                valid_pipe[stage] <= valid_pipe[stage - 1];
            end
        end
    end

    // Index rides alongside, meaningful only with its valid bit
    always_ff @(posedge clock) begin
        index_pipe[0] <= read_request.index;
        for (int stage = 1; stage < READ_LATENCY; stage++) begin
            index_pipe[stage] <= index_pipe[stage - 1];
        end
    end

    // Last stage lines up with the RAM output
    assign read_response.valid  = valid_pipe[READ_LATENCY - 1];
    assign read_response.index  = index_pipe[READ_LATENCY - 1];
    assign read_response.sample = read_data;

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Every response traces back to an accepted request whose window stayed put
    response_follows_request: assert property (
        @(posedge clock) disable iff (!reset_n)
        read_response.valid |-> $past(request_accepted, READ_LATENCY)
            && window_start + read_response.index == $past(read_address, READ_LATENCY)
    );

endmodule

// ==== hdl/capture_buffer_top.sv ====
module capture_buffer_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  sample_pkg::sample_beat_t    sample_in,
    input  logic                        rearm,
    input  capture_pkg::read_request_t  read_request,
    output capture_pkg::read_response_t read_response,
    output capture_pkg::capture_state_t capture_state
);

    import sample_pkg::*;
    import capture_pkg::*;

    // Write side
    logic                     write_enable;
    logic [ADDRESS_WIDTH-1:0] write_address;
    sample_t                  write_data;

    // Hand-off from capture to readout
    logic                     frozen;
    logic [ADDRESS_WIDTH-1:0] window_start;

    // Read side
    logic [ADDRESS_WIDTH-1:0] read_address;
    sample_t                  read_data;

    capture_write_control write_control (
        .clock         (clock),
        .reset_n       (reset_n),
        .sample_in     (sample_in),
        .rearm         (rearm),
        .capture_state (capture_state),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .frozen        (frozen),
        .window_start  (window_start)
    );

    capture_readout readout (
        .clock         (clock),
        .reset_n       (reset_n),
        .read_request  (read_request),
        .frozen        (frozen),
        .window_start  (window_start),
        .read_data     (read_data),
        .read_address  (read_address),
        .read_response (read_response)
    );

    generic_block_ram #(
        .DATA_WIDTH       ($bits(sample_t)),
        .DATA_DEPTH       (BUFFER_DEPTH),
        .PIPELINED_OUTPUT (READ_PIPELINED)
    ) history_ram (
        .clock         (clock),
        .reset_n       (reset_n),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .write_address (write_address),
        .read_address  (read_address),
        .read_data     (read_data)
    );

endmodule

// ==== test/capture_buffer_checker.sv ====
module capture_buffer_checker (
    input  logic                        clock,
    input  logic                        reset_n,
    input  sample_pkg::sample_beat_t    sample_in,
    input  logic                        rearm,
    input  capture_pkg::read_request_t  read_request,
    input  capture_pkg::read_response_t read_response,
    input  capture_pkg::capture_state_t capture_state,
    input  logic                        step_done,
    input  int                          step_number,
    input  capture_pkg::capture_state_t step_state,
    output int                          error_count,
    output int                          response_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import sample_pkg::*;
    import capture_pkg::*;

    typedef struct packed {
        int                       due;
        logic [ADDRESS_WIDTH-1:0] index;
        sample_t                  sample;
    } pending_t;

    sample_t                  model_mem [BUFFER_DEPTH];
    capture_state_t           model_state;
    logic [ADDRESS_WIDTH-1:0] write_pointer;
    int                       trigger_address;
    int                       window_address;
    int                       fill_count;
    int                       post_count;
    int                       cycle;
    int                       step_start;
    pending_t                 pending [$];
    pending_t                 entry;

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            model_mem       = '{default: '0};
            model_state     = FILLING;
            write_pointer   = '0;
            trigger_address = 0;
            window_address  = 0;
            fill_count      = 0;
            post_count      = 0;
            cycle           = 0;
            step_start      = 0;
            error_count     = 0;
            response_count  = 0;
            pending.delete();
        end else begin
            cycle++;

            // State must track the model on every edge
            if (capture_state !== model_state) begin
                $display("mismatch at %0t: capture_state expected %s got %s",
                         $time, model_state.name(), capture_state.name());
                error_count++;
            end

            //////////////////////////////
            // Responses
            //////////////////////////////
            if (pending.size() > 0 && pending[0].due == cycle) begin
                entry = pending.pop_front();
                if (!read_response.valid) begin
                    $display("response for index %0d missing at %0t", entry.index, $time);
                    error_count++;
                end else begin
                    response_count++;
                    if (read_response.index !== entry.index) begin
                        $display("mismatch at %0t: read_response.index expected %0d got %0d",
                                 $time, entry.index, read_response.index);
                        error_count++;
                    end
                    if (read_response.sample !== entry.sample) begin
                        $display("mismatch at %0t: read_response.sample expected %h got %h",
                                 $time, entry.sample, read_response.sample);
                        error_count++;
                    end
                end
            end else if (read_response.valid) begin
                $display("unexpected response for index %0d at %0t",
                         read_response.index, $time);
                error_count++;
                response_count++;
            end

            // Requests count only while the model holds a frozen window
            if (read_request.valid && model_state == FROZEN) begin
                // Window index 0 sits PRETRIGGER_COUNT entries behind the trigger
                window_address = (trigger_address + BUFFER_DEPTH - PRETRIGGER_COUNT
                                  + read_request.index) % BUFFER_DEPTH;
                entry.due    = cycle + READ_LATENCY;
                entry.index  = read_request.index;
                entry.sample = model_mem[window_address];
                pending.push_back(entry);
            end

            //////////////////////////////
            // Capture model
            //////////////////////////////
            if (sample_in.valid && model_state != FROZEN) begin
                model_mem[write_pointer] = sample_in.sample;
                case (model_state)
                    FILLING: begin
                        fill_count++;
                        if (fill_count == PRETRIGGER_COUNT) begin
                            model_state = ARMED;
                        end
                    end
                    ARMED: begin
                        if (sample_in.trigger) begin
                            trigger_address = write_pointer;
                            post_count      = 0;
                            model_state     = TRIGGERED;
                        end
                    end
                    default: begin
                        post_count++;
                        if (post_count == POSTTRIGGER_COUNT) begin
                            model_state = FROZEN;
                        end
                    end
                endcase
                write_pointer = write_pointer + 1'b1;
            end else if (model_state == FROZEN && rearm) begin
                model_state = FILLING;
                fill_count  = 0;
            end

            // One line per finished step
            if (step_done) begin
                if (capture_state !== step_state) begin
                    $display("mismatch at %0t: capture_state expected %s got %s",
                             $time, step_state.name(), capture_state.name());
                    error_count++;
                end
                $display("step %0d done at %0t: state %s, %0d responses, %0d errors so far",
                         step_number, $time, capture_state.name(),
                         response_count - step_start, error_count);
                step_start = response_count;
            end
        end
    end

endmodule

// ==== test/capture_buffer_tb.sv ====
module capture_buffer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import sample_pkg::*;
    import capture_pkg::*;

    typedef enum {
        STREAM,
        READ_WINDOW,
        READ_UNFROZEN,
        REARM,
        CHECK_STATE
    } step_kind_t;

    typedef struct {
        step_kind_t     kind;
        int             count;
        int             trigger_position;
        capture_state_t state;
    } step_t;

    localparam int STEP_COUNT       = 17;
    localparam int STATE_TIMEOUT    = 64;
    localparam int RESPONSE_TIMEOUT = BUFFER_DEPTH + 16;

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    // Kind, sample or request count, trigger position (-1 for none), state afterwards
    // Second capture triggers at address 48 so its window starts at 240
    step_t steps [STEP_COUNT] = '{
        '{CHECK_STATE,   0,            -1,  FILLING},
        '{READ_UNFROZEN, 4,            -1,  FILLING},
        '{STREAM,        40,           10,  FILLING},
        '{STREAM,        24,           -1,  ARMED},
        '{STREAM,        10,           5,   TRIGGERED},
        '{READ_UNFROZEN, 8,            -1,  TRIGGERED},
        '{STREAM,        186,          -1,  TRIGGERED},
        '{STREAM,        1,            -1,  FROZEN},
        '{STREAM,        20,           3,   FROZEN},
        '{READ_WINDOW,   BUFFER_DEPTH, -1,  FROZEN},
        '{REARM,         0,            -1,  FILLING},
        '{STREAM,        64,           -1,  ARMED},
        '{REARM,         0,            -1,  ARMED},
        '{STREAM,        240,          235, TRIGGERED},
        '{STREAM,        187,          -1,  FROZEN},
        '{READ_WINDOW,   BUFFER_DEPTH, -1,  FROZEN},
        '{CHECK_STATE,   0,            -1,  FROZEN}
    };

    logic           clock;
    logic           reset_n;
    sample_beat_t   sample_in;
    logic           rearm;
    read_request_t  read_request;
    read_response_t read_response;
    capture_state_t capture_state;
    logic           step_done;
    int             step_number;
    capture_state_t step_state;
    int             error_count;
    int             response_count;
    int             timeout_count;

    always #4 clock = ~clock;

    capture_buffer_top uut (
        .clock         (clock),
        .reset_n       (reset_n),
        .sample_in     (sample_in),
        .rearm         (rearm),
        .read_request  (read_request),
        .read_response (read_response),
        .capture_state (capture_state)
    );

    capture_buffer_checker response_checker (
        .clock          (clock),
        .reset_n        (reset_n),
        .sample_in      (sample_in),
        .rearm          (rearm),
        .read_request   (read_request),
        .read_response  (read_response),
        .capture_state  (capture_state),
        .step_done      (step_done),
        .step_number    (step_number),
        .step_state     (step_state),
        .error_count    (error_count),
        .response_count (response_count)
    );

    //////////////////////////////
    // Drivers
    //////////////////////////////

    // Random values with an occasional idle cycle in between
    task automatic drive_samples(input int count, input int trigger_position);
        sample_beat_t beat;
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(3) == 0) begin
                @(posedge clock);
                sample_in <= '0;
            end
            beat.valid                = 1'b1;
            beat.trigger              = (i == trigger_position);
            beat.sample.channel       = CHANNEL_WIDTH'($urandom);
            beat.sample.value         = VALUE_WIDTH'($urandom);
            @(posedge clock);
            sample_in <= beat;
        end
        @(posedge clock);
        sample_in <= '0;
    endtask

    // Back-to-back requests from index 0 upwards
    task automatic read_indices(input int count);
        read_request_t request;
        for (int i = 0; i < count; i++) begin
            request.valid = 1'b1;
            request.index = ADDRESS_WIDTH'(i);
            @(posedge clock);
            read_request <= request;
        end
        @(posedge clock);
        read_request <= '0;
    endtask

    task automatic pulse_rearm();
        @(posedge clock);
        rearm <= 1'b1;
        @(posedge clock);
        rearm <= 1'b0;
    endtask

    //////////////////////////////
    // Waits
    //////////////////////////////

    task automatic wait_for_state(input capture_state_t target);
        int cycles;
        cycles = 0;
        while (capture_state !== target && cycles < STATE_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (capture_state !== target) begin
            $display("timeout: capture_state did not reach %s within %0d cycles",
                     target.name(), STATE_TIMEOUT);
            timeout_count++;
        end
    endtask

    // Checker counts settle on the rising edge, so look half a cycle later
    task automatic wait_for_responses(input int target);
        int cycles;
        cycles = 0;
        while (response_count < target && cycles < RESPONSE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (response_count < target) begin
            $display("timeout: only %0d of %0d responses arrived", response_count, target);
            timeout_count++;
        end
    endtask

    // Hands the step result to the checker for its report line
    task automatic finish_step(input int number, input capture_state_t state);
        @(posedge clock);
        step_done   <= 1'b1;
        step_number <= number;
        step_state  <= state;
        @(posedge clock);
        step_done <= 1'b0;
    endtask

    initial begin
        int target;
        clock         = 1'b0;
        reset_n       = 1'b0;
        sample_in     = '0;
        rearm         = 1'b0;
        read_request  = '0;
        step_done     = 1'b0;
        step_number   = 0;
        step_state    = FILLING;
        timeout_count = 0;
        void'($urandom(45044));
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;

        for (int s = 0; s < STEP_COUNT; s++) begin
            case (steps[s].kind)
                STREAM: drive_samples(steps[s].count, steps[s].trigger_position);
                READ_WINDOW: begin
                    target = response_count + steps[s].count;
                    read_indices(steps[s].count);
                    wait_for_responses(target);
                end
                READ_UNFROZEN: begin
                    read_indices(steps[s].count);
                    // Any stray response would surface within the read latency
                    repeat (READ_LATENCY + 1) @(posedge clock);
                end
                REARM: pulse_rearm();
                default: ;
            endcase
            wait_for_state(steps[s].state);
            finish_step(s, steps[s].state);
        end

        repeat (4) @(negedge clock);
        $display("%0d steps, %0d responses, %0d errors, %0d timeouts",
                 STEP_COUNT, response_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
common/sample_pkg.sv
common/capture_pkg.sv
hdl/generic_block_ram.sv
capture/capture_write_control.sv
capture/capture_readout.sv
hdl/capture_buffer_top.sv
test/capture_buffer_checker.sv
test/capture_buffer_tb.sv

// ==== Makefile ====
TOP := capture_buffer_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard common/*.sv hdl/*.sv capture/*.sv test/*.sv)
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --top-module capture_buffer_top \
		common/sample_pkg.sv common/capture_pkg.sv hdl/generic_block_ram.sv \
		capture/capture_write_control.sv capture/capture_readout.sv \
		hdl/capture_buffer_top.sv

clean:
	rm -rf obj_dir
